// ==== rtl/irq_pkg.sv ====
/*
 * interrupt controller shared definitions
 * sizes, command encoding, command and response structs,
 * response codes and the scanner offer record
 */
`default_nettype none

package irq_pkg;

	// bus word and word-address widths
	localparam int ARCH_W = 16;
	localparam int ADDR_W = 2;

	// number of sources and destinations
	localparam int SRC_N = 4;
	localparam int DST_N = 2;

	// index widths, derived from the counts above
	localparam int SRC_W = $clog2(SRC_N);
	localparam int DST_W = $clog2(DST_N);

	// argument / response field, everything above the 2-bit cmd
	localparam int ARG_W = ARCH_W - 2;

	// command opcodes, low 2 bits of every written word
	typedef enum logic [1:0] {
		CMD_DEVRDY = 2'b00,
		CMD_ACKINT = 2'b01,
		CMD_INTDST = 2'b10,
		CMD_ENAINT = 2'b11
	} cmd_e;

	// layout of a bus word; also used for the response register
	typedef struct packed {
		logic [ARG_W-1:0] arg;
		cmd_e             cmd;
	} cmd_word_t;

	// command handed from the port to its owner
	typedef struct packed {
		logic             valid;
		cmd_e             cmd;
		logic [ARG_W-1:0] arg;
	} cmd_req_t;

	// result returned by the owner in the same cycle
	typedef struct packed {
		logic             valid;
		logic [ARG_W-1:0] resp;
	} resp_t;

	// -1 and -2 in the response field
	localparam logic [ARG_W-1:0] RESP_INVALID = {ARG_W{1'b1}};
	localparam logic [ARG_W-1:0] RESP_BUSY    = {{(ARG_W-1){1'b1}}, 1'b0};

	// scanner offer: current source is enabled and requesting
	typedef struct packed {
		logic             valid;
		logic [SRC_W-1:0] idx;
	} src_offer_t;

endpackage

`default_nettype wire

// ==== rtl/irq_cmd_port.sv ====
/*
 * wishbone-style slave for the interrupt controller
 * registers accesses, gates commands on the ready state,
 * routes them to scanner or dispatcher, holds the response
 */
`timescale 1ns/1ps
`default_nettype none

module irq_cmd_port (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire                          cyc_i,
	input  wire                          stb_i,
	input  wire                          we_i,
	input  wire [irq_pkg::ADDR_W-1:0]    addr_i,
	input  wire [irq_pkg::ARCH_W-1:0]    dat_i,
	output logic                         ack_o,
	output logic [irq_pkg::ARCH_W-1:0]   dat_o,
	output irq_pkg::cmd_req_t            scan_req_o,
	output irq_pkg::cmd_req_t            disp_req_o,
	input  wire irq_pkg::resp_t          scan_resp_i,
	input  wire irq_pkg::resp_t          disp_resp_i,
	output logic                         cmd_idle_o
);

	logic                stb_q;
	logic                we_q;
	irq_pkg::cmd_word_t  wr_q;
	irq_pkg::cmd_word_t  resp_q;
	logic                wr_fire;
	logic                devrdy;
	logic                cmd_fire;

	// strobe, write flag and word captured one cycle after the access
	// ack follows one more cycle later, so 2 cycles after the strobe
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			stb_q <= 1'b0;
			ack_o <= 1'b0;
		end else begin
			stb_q <= cyc_i && stb_i;
			ack_o <= stb_q;
		end
	end

	// single location: only writes to word 0 carry a command
	always_ff @(posedge clk_i) begin
		if (cyc_i && stb_i) begin
			we_q <= we_i && (addr_i == '0);
			wr_q <= dat_i;
		end
	end

	// controller takes a new command only once the last result was DEVRDY
	assign cmd_idle_o = (resp_q.cmd == irq_pkg::CMD_DEVRDY);

	assign wr_fire  = stb_q && we_q;
	assign devrdy   = wr_fire && (wr_q.cmd == irq_pkg::CMD_DEVRDY);
	assign cmd_fire = wr_fire && cmd_idle_o && (wr_q.cmd != irq_pkg::CMD_DEVRDY);

	// ENAINT belongs to the scanner, the rest to the dispatcher
	always_comb begin
		scan_req_o.valid = cmd_fire && (wr_q.cmd == irq_pkg::CMD_ENAINT);
		scan_req_o.cmd   = wr_q.cmd;
		scan_req_o.arg   = wr_q.arg;
		disp_req_o.valid = cmd_fire && (wr_q.cmd != irq_pkg::CMD_ENAINT);
		disp_req_o.cmd   = wr_q.cmd;
		disp_req_o.arg   = wr_q.arg;
	end

	// response register: DEVRDY clears it, a served command loads cmd and result
	// a gated-off write falls through and leaves it alone
	always_ff @(posedge clk_i) begin
		if (rst_i || devrdy) begin
			resp_q <= '0;
		end else if (scan_resp_i.valid) begin
			resp_q.cmd <= wr_q.cmd;
			resp_q.arg <= scan_resp_i.resp;
		end else if (disp_resp_i.valid) begin
			resp_q.cmd <= wr_q.cmd;
			resp_q.arg <= disp_resp_i.resp;
		end
	end

	// reads always see the last result
	assign dat_o = resp_q;

	// one access at a time, so ack is a lone pulse
	a_ack_single: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |=> !ack_o);

	// scanner and dispatcher never answer together
	a_resp_one: assert property (@(posedge clk_i) disable iff (rst_i)
		!(scan_resp_i.valid && disp_resp_i.valid));

endmodule

`default_nettype wire

// ==== rtl/irq_src_scan.sv ====
/*
 * interrupt source scanner
 * source enable mask with ENAINT handling and
 * round-robin offer of the next requesting source
 */
`timescale 1ns/1ps
`default_nettype none

module irq_src_scan (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire irq_pkg::cmd_req_t       req_i,
	output irq_pkg::resp_t               resp_o,
	input  wire [irq_pkg::SRC_N-1:0]     intrqstsrc_i,
	input  wire                          src_take_i,
	output irq_pkg::src_offer_t          offer_o
);

	logic [irq_pkg::SRC_N-1:0]   en_q;
	logic [irq_pkg::SRC_W-1:0]   idx_q;
	logic [irq_pkg::SRC_W-1:0]   idx_next;
	logic [irq_pkg::ARG_W-2:0]   arg_idx;
	logic                        arg_ok;
	logic                        ena_fire;

	// ENAINT arg: index above, enable in bit 0
	assign arg_idx  = req_i.arg[irq_pkg::ARG_W-1:1];
	assign arg_ok   = (arg_idx < irq_pkg::SRC_N);
	assign ena_fire = req_i.valid && (req_i.cmd == irq_pkg::CMD_ENAINT);

	// answer in the same cycle: the index, or -1 when out of range
	always_comb begin
		resp_o.valid = ena_fire;
		if (arg_ok) begin
			resp_o.resp = {{(irq_pkg::ARG_W-irq_pkg::SRC_W){1'b0}},
				arg_idx[irq_pkg::SRC_W-1:0]};
		end else begin
			resp_o.resp = irq_pkg::RESP_INVALID;
		end
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			en_q <= '0;
		end else if (ena_fire && arg_ok) begin
			en_q[arg_idx[irq_pkg::SRC_W-1:0]] <= req_i.arg[0];
		end
	end

	// offer the indexed source while it is enabled and raising a request
	assign offer_o.valid = en_q[idx_q] && intrqstsrc_i[idx_q];
	assign offer_o.idx   = idx_q;

	// wrap at SRC_N, which need not be a power of two
	assign idx_next = (idx_q == irq_pkg::SRC_W'(irq_pkg::SRC_N-1)) ? '0 : idx_q + 1'b1;

	// step on after the dispatcher took the offer, or when nothing to offer
	// otherwise hold so the dispatcher can keep searching a destination
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			idx_q <= '0;
		end else if (src_take_i || !offer_o.valid) begin
			idx_q <= idx_next;
		end
	end

	// a source disabled by ENAINT is not offered on the following cycle
	a_no_disabled: assert property (@(posedge clk_i) disable iff (rst_i)
		(ena_fire && arg_ok && !req_i.arg[0]) |=>
		!(offer_o.valid && offer_o.idx == $past(arg_idx[irq_pkg::SRC_W-1:0])));

endmodule

`default_nettype wire

// ==== rtl/irq_dispatch.sv ====
/*
 * interrupt destination dispatcher
 * one-entry pending record, destination search with preference,
 * INTDST and ACKINT handling, source/destination handshakes
 */
`timescale 1ns/1ps
`default_nettype none

module irq_dispatch (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire irq_pkg::cmd_req_t       req_i,
	output irq_pkg::resp_t               resp_o,
	input  wire                          cmd_idle_i,
	input  wire irq_pkg::src_offer_t     offer_i,
	output logic                         src_take_o,
	input  wire [irq_pkg::DST_N-1:0]     intrdydst_i,
	input  wire [irq_pkg::DST_N-1:0]     intbestdst_i,
	output logic [irq_pkg::DST_N-1:0]    intrqstdst_o,
	output logic [irq_pkg::SRC_N-1:0]    intrdysrc_o
);

	// pending record
	logic                        pend_q;
	logic                        dir_q;
	logic [irq_pkg::SRC_W-1:0]   src_q;
	// search index, doubles as the target once pending
	logic [irq_pkg::DST_W-1:0]   dst_q;
	logic [irq_pkg::DST_N-1:0]   den_q;

	logic [irq_pkg::DST_W-1:0]   dst_next;
	logic                        any_best;
	logic                        dst_hit;
	logic                        intdst_fire;
	logic                        intdst_ok;
	logic                        ackint_fire;
	logic [irq_pkg::ARG_W-2:0]   ack_idx;
	logic                        ack_ok;
	logic                        ack_hit;

	// INTDST carries the bare destination index in arg
	assign intdst_fire = req_i.valid && (req_i.cmd == irq_pkg::CMD_INTDST);
	assign intdst_ok   = (req_i.arg < irq_pkg::DST_N);

	// ACKINT arg: destination index above, enable in bit 0
	assign ackint_fire = req_i.valid && (req_i.cmd == irq_pkg::CMD_ACKINT);
	assign ack_idx     = req_i.arg[irq_pkg::ARG_W-1:1];
	assign ack_ok      = (ack_idx < irq_pkg::DST_N);
	assign ack_hit     = pend_q && (ack_idx == {{(irq_pkg::ARG_W-1-irq_pkg::DST_W){1'b0}}, dst_q});

	// a best destination wins; plain ready counts only if no enabled one is best
	assign any_best = |(intbestdst_i & den_q);
	assign dst_hit  = den_q[dst_q] &&
		(intbestdst_i[dst_q] || (!any_best && intrdydst_i[dst_q]));

	assign dst_next = (dst_q == irq_pkg::DST_W'(irq_pkg::DST_N-1)) ? '0 : dst_q + 1'b1;

	// latch only on a quiet cycle with the port ready for software,
	// since the request line stays low otherwise
	assign src_take_o = !req_i.valid && !pend_q && offer_i.valid && dst_hit && cmd_idle_i;

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			pend_q <= 1'b0;
			dir_q  <= 1'b0;
			dst_q  <= '0;
			den_q  <= '0;
		end else if (intdst_fire) begin
			// directed request, target loaded straight away
			if (intdst_ok && !pend_q) begin
				pend_q <= 1'b1;
				dir_q  <= 1'b1;
				dst_q  <= req_i.arg[irq_pkg::DST_W-1:0];
			end
		end else if (ackint_fire) begin
			if (ack_hit) begin
				pend_q <= 1'b0;
				dir_q  <= 1'b0;
				// search restarts from destination 0
				dst_q  <= '0;
			end
			if (ack_ok) begin
				den_q[ack_idx[irq_pkg::DST_W-1:0]] <= req_i.arg[0];
			end
		end else if (!pend_q && offer_i.valid) begin
			if (dst_hit) begin
				if (cmd_idle_i) begin
					pend_q <= 1'b1;
					dir_q  <= 1'b0;
				end
			end else begin
				// not suitable, try the next destination
				dst_q <= dst_next;
			end
		end
	end

	// source index is payload, only meaningful while pending
	always_ff @(posedge clk_i) begin
		if (src_take_o) begin
			src_q <= offer_i.idx;
		end
	end

	// same-cycle result for the port
	always_comb begin
		resp_o.valid = intdst_fire || ackint_fire;
		resp_o.resp  = irq_pkg::RESP_INVALID;
		if (intdst_fire) begin
			if (!intdst_ok) begin
				resp_o.resp = irq_pkg::RESP_INVALID;
			end else if (pend_q) begin
				resp_o.resp = irq_pkg::RESP_BUSY;
			end else begin
				resp_o.resp = req_i.arg;
			end
		end else if (ackint_fire) begin
			if (!ack_hit) begin
				resp_o.resp = irq_pkg::RESP_BUSY;
			end else if (dir_q) begin
				// directed requests have no source to report
				resp_o.resp = irq_pkg::RESP_INVALID;
			end else begin
				resp_o.resp = {{(irq_pkg::ARG_W-irq_pkg::SRC_W){1'b0}}, src_q};
			end
		end
	end

	// request line to the target, held off while a command result is outstanding
	always_comb begin
		for (int d = 0; d < irq_pkg::DST_N; d++) begin
			intrqstdst_o[d] = pend_q && cmd_idle_i && (dst_q == irq_pkg::DST_W'(d));
		end
	end

	// latched source sees intrdy low until acknowledged
	always_comb begin
		for (int s = 0; s < irq_pkg::SRC_N; s++) begin
			intrdysrc_o[s] = !(pend_q && !dir_q && (src_q == irq_pkg::SRC_W'(s)));
		end
	end

	a_dst_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
		$onehot0(intrqstdst_o));

	// a raised request never hops to another destination without dropping first
	a_dst_stable: assert property (@(posedge clk_i) disable iff (rst_i)
		(intrqstdst_o != '0) |=>
		((intrqstdst_o == '0) || (intrqstdst_o == $past(intrqstdst_o))));

endmodule

`default_nettype wire

// ==== rtl/irq_top.sv ====
/*
 * interrupt controller top level
 * command port, source scanner and destination dispatcher
 */
`timescale 1ns/1ps
`default_nettype none

module irq_top (
	input  wire                          clk_i,
	input  wire                          rst_i,
	input  wire                          cyc_i,
	input  wire                          stb_i,
	input  wire                          we_i,
	input  wire [irq_pkg::ADDR_W-1:0]    addr_i,
	input  wire [irq_pkg::ARCH_W-1:0]    dat_i,
	output logic                         ack_o,
	output logic [irq_pkg::ARCH_W-1:0]   dat_o,
	output logic [irq_pkg::DST_N-1:0]    intrqstdst_o,
	input  wire [irq_pkg::DST_N-1:0]     intrdydst_i,
	input  wire [irq_pkg::DST_N-1:0]     intbestdst_i,
	input  wire [irq_pkg::SRC_N-1:0]     intrqstsrc_i,
	output logic [irq_pkg::SRC_N-1:0]    intrdysrc_o
);

	irq_pkg::cmd_req_t    scan_req;
	irq_pkg::cmd_req_t    disp_req;
	irq_pkg::resp_t       scan_resp;
	irq_pkg::resp_t       disp_resp;
	irq_pkg::src_offer_t  src_offer;
	logic                 src_take;
	logic                 cmd_idle;

	irq_cmd_port u_cmd_port (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.cyc_i       (cyc_i),
		.stb_i       (stb_i),
		.we_i        (we_i),
		.addr_i      (addr_i),
		.dat_i       (dat_i),
		.ack_o       (ack_o),
		.dat_o       (dat_o),
		.scan_req_o  (scan_req),
		.disp_req_o  (disp_req),
		.scan_resp_i (scan_resp),
		.disp_resp_i (disp_resp),
		.cmd_idle_o  (cmd_idle)
	);

	irq_src_scan u_src_scan (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req_i        (scan_req),
		.resp_o       (scan_resp),
		.intrqstsrc_i (intrqstsrc_i),
		.src_take_i   (src_take),
		.offer_o      (src_offer)
	);

	irq_dispatch u_dispatch (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.req_i        (disp_req),
		.resp_o       (disp_resp),
		.cmd_idle_i   (cmd_idle),
		.offer_i      (src_offer),
		.src_take_o   (src_take),
		.intrdydst_i  (intrdydst_i),
		.intbestdst_i (intbestdst_i),
		.intrqstdst_o (intrqstdst_o),
		.intrdysrc_o  (intrdysrc_o)
	);

endmodule

`default_nettype wire

// ==== bench/irq_tb_checks.svh ====
/*
 * testbench checks: ack timing, read data and interrupt lines
 * as concurrent assertions, plus the per-test counters
 */
`ifndef IRQ_TB_CHECKS_SVH
`define IRQ_TB_CHECKS_SVH

	int err_cnt   = 0;
	int err_mark  = 0;
	int test_pass = 0;
	int test_fail = 0;

	// ack exactly 2 cycles after each strobe
	ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		$past(cyc_i && stb_i, 2) |-> ack_o)
		else begin
			$display("FAILED at %0t: ack_o expected 1, got 0", $time);
			err_cnt++;
		end

	// and never without one
	ack_only_stb: assert property (@(posedge clk_i) disable iff (rst_i)
		ack_o |-> $past(cyc_i && stb_i, 2))
		else begin
			$display("FAILED at %0t: ack_o expected 0, got 1", $time);
			err_cnt++;
		end

	read_data: assert property (@(posedge clk_i) disable iff (rst_i)
		(ack_o && rd_chk) |-> (dat_o == rd_exp))
		else begin
			$display("FAILED at %0t: dat_o expected %h, got %h", $time,
				$sampled(rd_exp), $sampled(dat_o));
			err_cnt++;
		end

	dst_lines: assert property (@(posedge clk_i) disable iff (rst_i)
		line_chk |-> (intrqstdst_o == dst_exp))
		else begin
			$display("FAILED at %0t: intrqstdst_o expected %b, got %b", $time,
				$sampled(dst_exp), $sampled(intrqstdst_o));
			err_cnt++;
		end

	src_lines: assert property (@(posedge clk_i) disable iff (rst_i)
		line_chk |-> (intrdysrc_o == src_exp))
		else begin
			$display("FAILED at %0t: intrdysrc_o expected %b, got %b", $time,
				$sampled(src_exp), $sampled(intrdysrc_o));
			err_cnt++;
		end

	task automatic start_test();
		err_mark = err_cnt;
	endtask

	// one line per finished test
	task automatic report_test(input string name);
		if (err_cnt == err_mark) begin
			test_pass++;
			$display("test %s: ok", name);
		end else begin
			test_fail++;
			$display("test %s: failed with %0d errors", name, err_cnt - err_mark);
		end
	endtask

`endif

// ==== bench/irq_tb.sv ====
/*
 * testbench for the interrupt controller
 * clock, reset, bus tasks, six tests and the closing report
 */
`timescale 1ns/1ps
`default_nettype none

module irq_tb;

	// six tests of at most 600 cycles plus reset and margin
	localparam int TEST_N      = 6;
	localparam int TEST_CYC    = 600;
	localparam int TIMEOUT_CYC = TEST_N * TEST_CYC + 400;
	localparam int WAIT_MAX    = 200;

	typedef logic [irq_pkg::ARG_W-1:0] arg_t;

	logic                          clk_i;
	logic                          rst_i;
	logic                          cyc_i;
	logic                          stb_i;
	logic                          we_i;
	logic [irq_pkg::ADDR_W-1:0]    addr_i;
	logic [irq_pkg::ARCH_W-1:0]    dat_i;
	logic                          ack_o;
	logic [irq_pkg::ARCH_W-1:0]    dat_o;
	logic [irq_pkg::DST_N-1:0]     intrqstdst_o;
	logic [irq_pkg::DST_N-1:0]     intrdydst_i;
	logic [irq_pkg::DST_N-1:0]     intbestdst_i;
	logic [irq_pkg::SRC_N-1:0]     intrqstsrc_i;
	logic [irq_pkg::SRC_N-1:0]     intrdysrc_o;

	// expected values picked up by the checks
	logic                          rd_chk;
	logic [irq_pkg::ARCH_W-1:0]    rd_exp;
	logic                          line_chk;
	logic [irq_pkg::DST_N-1:0]     dst_exp;
	logic [irq_pkg::SRC_N-1:0]     src_exp;
	integer                        seed;
	int                            cycle_cnt;

	`include "irq_tb_checks.svh"

	irq_top u_irq_top (
		.clk_i        (clk_i),
		.rst_i        (rst_i),
		.cyc_i        (cyc_i),
		.stb_i        (stb_i),
		.we_i         (we_i),
		.addr_i       (addr_i),
		.dat_i        (dat_i),
		.ack_o        (ack_o),
		.dat_o        (dat_o),
		.intrqstdst_o (intrqstdst_o),
		.intrdydst_i  (intrdydst_i),
		.intbestdst_i (intbestdst_i),
		.intrqstsrc_i (intrqstsrc_i),
		.intrdysrc_o  (intrdysrc_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	// bus word with the result or argument above the cmd in the low 2 bits
	function automatic logic [irq_pkg::ARCH_W-1:0] cmd_word(input irq_pkg::cmd_e c,
		input arg_t v);
		return {v, c};
	endfunction

	// ENAINT and ACKINT argument with the index above the enable in bit 0
	function automatic arg_t idx_arg(input int idx, input logic en);
		return {idx[irq_pkg::ARG_W-2:0], en};
	endfunction

	// ack is seen one edge after it rises
	task automatic wait_ack();
		do @(posedge clk_i); while (!ack_o);
	endtask

	task automatic bus_write(input logic [irq_pkg::ARCH_W-1:0] d);
		@(posedge clk_i);
		cyc_i  <= 1'b1;
		stb_i  <= 1'b1;
		we_i   <= 1'b1;
		addr_i <= '0;
		dat_i  <= d;
		@(posedge clk_i);
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		we_i  <= 1'b0;
		wait_ack();
	endtask

	// read data is compared while ack is high
	task automatic bus_read(input logic [irq_pkg::ARCH_W-1:0] exp);
		@(posedge clk_i);
		cyc_i  <= 1'b1;
		stb_i  <= 1'b1;
		we_i   <= 1'b0;
		addr_i <= '0;
		rd_exp <= exp;
		rd_chk <= 1'b1;
		@(posedge clk_i);
		cyc_i <= 1'b0;
		stb_i <= 1'b0;
		wait_ack();
		rd_chk <= 1'b0;
	endtask

	// command and its result followed by DEVRDY to re-arm the port
	task automatic run_cmd(input irq_pkg::cmd_e c, input arg_t arg, input arg_t resp);
		bus_write(cmd_word(c, arg));
		bus_read(cmd_word(c, resp));
		bus_write(cmd_word(irq_pkg::CMD_DEVRDY, '0));
		bus_read('0);
	endtask

	// one-cycle window in which both interrupt line groups are compared
	task automatic check_lines(input logic [irq_pkg::DST_N-1:0] dst,
		input logic [irq_pkg::SRC_N-1:0] src);
		@(posedge clk_i);
		line_chk <= 1'b1;
		dst_exp  <= dst;
		src_exp  <= src;
		@(posedge clk_i);
		line_chk <= 1'b0;
	endtask

	task automatic wait_dst(input int d);
		int n;
		n = 0;
		while (!intrqstdst_o[d] && n < WAIT_MAX) begin
			@(posedge clk_i);
			n++;
		end
		if (!intrqstdst_o[d]) begin
			$display("no request on destination %0d within %0d cycles", d, WAIT_MAX);
			err_cnt++;
		end
	endtask

	initial begin
		int k;
		logic en;
		seed = 82;
		rst_i        <= 1'b1;
		cyc_i        <= 1'b0;
		stb_i        <= 1'b0;
		we_i         <= 1'b0;
		addr_i       <= '0;
		dat_i        <= '0;
		intrdydst_i  <= '0;
		intbestdst_i <= '0;
		intrqstsrc_i <= '0;
		rd_chk       <= 1'b0;
		rd_exp       <= '0;
		line_chk     <= 1'b0;
		dst_exp      <= '0;
		src_exp      <= '0;
		repeat (4) @(posedge clk_i);
		rst_i <= 1'b0;

		start_test();
		check_lines('0, '1);
		bus_read('0);
		report_test("reset");

		// random indices with some past SRC_N
		start_test();
		for (int i = 0; i < 6; i++) begin
			k  = $random(seed) & 7;
			en = 1'($random(seed));
			run_cmd(irq_pkg::CMD_ENAINT, idx_arg(k, en),
				(k < irq_pkg::SRC_N) ? arg_t'(k) : irq_pkg::RESP_INVALID);
		end
		run_cmd(irq_pkg::CMD_ENAINT, idx_arg(irq_pkg::SRC_N, 1'b1), irq_pkg::RESP_INVALID);
		// leave source 2 as the only enabled one
		for (int s = 0; s < irq_pkg::SRC_N; s++) begin
			run_cmd(irq_pkg::CMD_ENAINT, idx_arg(s, s == 2), arg_t'(s));
		end
		report_test("enaint");

		// enabling destinations answers busy while nothing is pending
		start_test();
		run_cmd(irq_pkg::CMD_ACKINT, idx_arg(0, 1'b1), irq_pkg::RESP_BUSY);
		run_cmd(irq_pkg::CMD_ACKINT, idx_arg(1, 1'b1), irq_pkg::RESP_BUSY);
		@(posedge clk_i);
		intrdydst_i  <= 2'b10;
		intbestdst_i <= 2'b00;
		// noise on disabled sources is never dispatched
		intrqstsrc_i <= 4'($random(seed)) | 4'b0100;
		wait_dst(1);
		check_lines(2'b10, 4'b1011);
		@(posedge clk_i);
		intrqstsrc_i <= '0;
		run_cmd(irq_pkg::CMD_ACKINT, idx_arg(1, 1'b1), arg_t'(2));
		check_lines('0, '1);
		report_test("dispatch");

		// both ready with destination 1 best
		start_test();
		@(posedge clk_i);
		intrdydst_i  <= 2'b11;
		intbestdst_i <= 2'b10;
		intrqstsrc_i <= 4'b0100;
		wait_dst(1);
		check_lines(2'b10, 4'b1011);
		@(posedge clk_i);
		intrqstsrc_i <= '0;
		run_cmd(irq_pkg::CMD_ACKINT, idx_arg(1, 1'b1), arg_t'(2));
		check_lines('0, '1);
		report_test("preference");

		start_test();
		intrdydst_i  <= '0;
		intbestdst_i <= '0;
		run_cmd(irq_pkg::CMD_INTDST, arg_t'(0), arg_t'(0));
		check_lines(2'b01, '1);
		run_cmd(irq_pkg::CMD_INTDST, arg_t'(1), irq_pkg::RESP_BUSY);
		run_cmd(irq_pkg::CMD_ACKINT, idx_arg(0, 1'b1), irq_pkg::RESP_INVALID);
		run_cmd(irq_pkg::CMD_INTDST, arg_t'(irq_pkg::DST_N), irq_pkg::RESP_INVALID);
		check_lines('0, '1);
		report_test("directed");

		// second command without DEVRDY is dropped
		start_test();
		bus_write(cmd_word(irq_pkg::CMD_ENAINT, idx_arg(1, 1'b1)));
		bus_read(cmd_word(irq_pkg::CMD_ENAINT, arg_t'(1)));
		bus_write(cmd_word(irq_pkg::CMD_INTDST, arg_t'(0)));
		bus_read(cmd_word(irq_pkg::CMD_ENAINT, arg_t'(1)));
		bus_write('0);
		bus_read('0);
		check_lines('0, '1);
		report_test("gating");

		$display("tests passed %0d, failed %0d, errors %0d", test_pass, test_fail, err_cnt);
		if (err_cnt == 0 && test_fail == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

	// run limit
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYC) begin
			@(posedge clk_i);
			cycle_cnt++;
		end
		$display("timeout: run did not end within %0d cycles", TIMEOUT_CYC);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+bench
rtl/irq_pkg.sv
rtl/irq_cmd_port.sv
rtl/irq_src_scan.sv
rtl/irq_dispatch.sv
rtl/irq_top.sv
bench/irq_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the interrupt controller testbench with Verilator, run it, scan the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f --top-module irq_tb -o irq_sim \
	&& ./obj_dir/irq_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "Simulation finished: FAIL" sim.log && exit 1
grep -q "Simulation finished: PASS" sim.log || exit 1
exit 0
